//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= modbus_resp_tx_tb
FILELIST  ?= modbus_resp_tx.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/modbus_resp_tx_checker.sv
`timescale 1ns/1ns

module modbus_resp_tx_checker
(
    input logic clk_in,
    input logic rst_n_in,
    input logic rs485_tx,
    input logic rs485_tx_en,
    input logic response_done
);

    int fail_cnt;

    // driver off means an idle line
    idle_line_high: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        !rs485_tx_en |-> rs485_tx)
    else
    begin
        $error("serial line low while the driver is disabled");
        fail_cnt++;
    end

    done_one_cycle: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        response_done |=> !response_done)
    else
    begin
        $error("response_done held longer than one cycle");
        fail_cnt++;
    end

    done_with_enable_fall: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        response_done |-> $fell(rs485_tx_en))
    else
    begin
        $error("response_done without the enable falling");
        fail_cnt++;
    end

    enable_fall_with_done: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        $fell(rs485_tx_en) |-> response_done)
    else
    begin
        $error("enable fell without response_done");
        fail_cnt++;
    end

endmodule

bind modbus_resp_tx modbus_resp_tx_checker checker_i
(
    .clk_in        (clk_in),
    .rst_n_in      (rst_n_in),
    .rs485_tx      (rs485_tx),
    .rs485_tx_en   (rs485_tx_en),
    .response_done (response_done)
);

//--- bench/modbus_resp_tx_tb.sv
`timescale 1ns/1ns

module modbus_resp_tx_tb;
    import modbus_pkg::*;

    localparam int     BIT_DIV     = 16;
    localparam int     GUARD       = int'(GUARD_BITS);
    localparam int     MAX_COUNT   = 8;
    localparam int     N_TESTS     = 10;
    localparam int     FRAME_MAX   = 5 + 2 * MAX_COUNT;
    localparam int     RUN_CYC     = (FRAME_MAX * 10 + 2 * GUARD) * BIT_DIV * 2;
    localparam longint WATCHDOG_NS = longint'(N_TESTS) * RUN_CYC * 10 + 1000;

    logic        clk_in;
    logic        rst_n_in;
    logic        start;
    resp_req_t   req;
    logic [7:0]  reg_addr;
    logic [15:0] reg_data;
    logic        rs485_tx;
    logic        rs485_tx_en;
    logic        response_done;

    logic [15:0] store [0:255];     // register store model
    logic [7:0]  exp_bytes [0:511];
    int          exp_addr [0:511];  // -1 unless a register high byte
    int          exp_cnt;
    logic [7:0]  act_bytes [0:511];
    int          act_addr [0:511];
    int          act_start [0:511];
    int          act_stop [0:511];
    int          act_cnt;
    int          cycle;
    int          en_rise_cyc;
    int          done_cyc;
    int          done_cnt;
    string       test_name;
    int          mismatch_errs;
    int          frame_errs;
    int          check_errs;

    assign reg_data = store[reg_addr];

    modbus_resp_tx #(.BAUD_DIV(16'(BIT_DIV))) dut_i
    (
        .clk_in        (clk_in),
        .rst_n_in      (rst_n_in),
        .start         (start),
        .req           (req),
        .reg_addr      (reg_addr),
        .reg_data      (reg_data),
        .rs485_tx      (rs485_tx),
        .rs485_tx_en   (rs485_tx_en),
        .response_done (response_done)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    always @(posedge clk_in)
        cycle <= cycle + 1;

    function automatic logic [15:0] crc_update(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        c = crc ^ {8'h00, b};
        for (int i = 0; i < 8; i++)
            c = c[0] ? ((c >> 1) ^ 16'hA001) : (c >> 1);
        return c;
    endfunction

    // builds the expected response and returns its length
    function automatic int build_frame(input logic [7:0] fc, input int count,
                                       input logic [15:0] regs [0:255],
                                       output logic [7:0] frame [0:FRAME_MAX-1]);
        logic [15:0] crc;
        int          n;
        frame[0] = 8'h01;
        frame[1] = fc;
        frame[2] = 8'(2 * count);
        n = 3;
        for (int k = 0; k < count; k++)
        begin
            frame[n]     = regs[k][15:8];
            frame[n + 1] = regs[k][7:0];
            n = n + 2;
        end
        crc = 16'hFFFF;
        for (int i = 0; i < n; i++)
            crc = crc_update(crc, frame[i]);
        frame[n]     = crc[7:0];    // low byte first
        frame[n + 1] = crc[15:8];
        return n + 2;
    endfunction

    task automatic run_test(input string name, input func_code_e fc, input int count,
                            input bit restart);
        logic [15:0] words [0:255];
        logic [7:0]  frame [0:FRAME_MAX-1];
        int          len;
        int          base;
        int          done_before;
        int          waited;
        int          last;
        test_name = name;
        for (int a = 0; a < 256; a++)
            words[a] = 16'($urandom);
        len  = build_frame(fc, count, words, frame);
        base = exp_cnt;
        for (int i = 0; i < len; i++)
        begin
            exp_bytes[base + i] = frame[i];
            exp_addr[base + i]  = (i >= 3 && i < 3 + 2 * count && i % 2 == 1) ? (i - 3) / 2 : -1;
        end
        exp_cnt     = base + len;
        done_before = done_cnt;
        @(posedge clk_in);
        for (int a = 0; a < 256; a++)
            store[a] <= words[a];
        start <= 1'b1;
        req   <= '{func: fc, reg_count: 8'(count)};
        @(posedge clk_in);
        start <= 1'b0;
        if (restart)
        begin
            repeat (40 * BIT_DIV) @(posedge clk_in); // well inside the frame
            start <= 1'b1;
            req   <= '{func: FC_READ_INPUT, reg_count: 8'd5};
            @(posedge clk_in);
            start <= 1'b0;
        end
        waited = 0;
        do
        begin
            @(negedge clk_in);
            waited++;
        end
        while (response_done !== 1'b1 && waited < RUN_CYC);
        assert (response_done === 1'b1)
        else
        begin
            $display("%s: response_done never came within %0d cycles", name, RUN_CYC);
            check_errs++;
        end
        repeat (4 * BIT_DIV) @(negedge clk_in);
        assert (done_cnt == done_before + 1)
        else
        begin
            $display("Mismatch %s done pulses: expected 1, actual %0d", name,
                     done_cnt - done_before);
            check_errs++;
        end
        assert (rs485_tx_en === 1'b0)
        else
        begin
            $display("%s: driver enable came back on after the response", name);
            check_errs++;
        end
        assert (act_cnt == base + len)
        else
        begin
            $display("Mismatch %s frame length: expected %0d, actual %0d", name, len,
                     act_cnt - base);
            check_errs++;
        end
        if (act_cnt == base + len)
        begin
            last = base + len - 1;
            assert (act_start[base] - en_rise_cyc >= GUARD * BIT_DIV)
            else
            begin
                $display("%s: enable led the first start bit by only %0d cycles", name,
                         act_start[base] - en_rise_cyc);
                check_errs++;
            end
            assert (done_cyc - (act_stop[last] + BIT_DIV / 2) >= (GUARD - 1) * BIT_DIV)
            else
            begin
                $display("%s: enable dropped too soon after the last stop bit", name);
                check_errs++;
            end
        end
    endtask

    // serial decoder sampling each bit at its middle
    initial
    begin
        logic [7:0] rx;
        act_cnt    = 0;
        frame_errs = 0;
        forever
        begin
            @(negedge clk_in);
            if (rst_n_in === 1'b1 && rs485_tx_en === 1'b1 && rs485_tx === 1'b0)
            begin
                act_start[act_cnt] = cycle;
                act_addr[act_cnt]  = int'(reg_addr);
                repeat (BIT_DIV / 2) @(negedge clk_in);
                assert (rs485_tx === 1'b0)
                else
                begin
                    $display("start bit of byte %0d did not stay low", act_cnt);
                    frame_errs++;
                end
                for (int b = 0; b < 8; b++)
                begin
                    repeat (BIT_DIV) @(negedge clk_in);
                    rx[b] = rs485_tx;
                end
                repeat (BIT_DIV) @(negedge clk_in);
                assert (rs485_tx === 1'b1)
                else
                begin
                    $display("stop bit of byte %0d missing", act_cnt);
                    frame_errs++;
                end
                act_stop[act_cnt]  = cycle;
                act_bytes[act_cnt] = rx;
                act_cnt++;
            end
        end
    end

    // enable rise and done pulses
    initial
    begin
        logic en_q;
        en_q     = 1'b0;
        done_cnt = 0;
        forever
        begin
            @(negedge clk_in);
            if (rs485_tx_en === 1'b1 && !en_q)
                en_rise_cyc = cycle;
            if (response_done === 1'b1)
            begin
                done_cnt++;
                done_cyc = cycle;
            end
            en_q = (rs485_tx_en === 1'b1);
        end
    end

    // compare process
    initial
    begin
        int rd_idx;
        rd_idx        = 0;
        mismatch_errs = 0;
        forever
        begin
            @(negedge clk_in);
            while (rd_idx < act_cnt)
            begin
                assert (rd_idx < exp_cnt)
                else
                begin
                    $display("%s: extra byte %h after the frame", test_name, act_bytes[rd_idx]);
                    mismatch_errs++;
                end
                if (rd_idx < exp_cnt)
                begin
                    assert (act_bytes[rd_idx] == exp_bytes[rd_idx])
                    else
                    begin
                        $display("Mismatch %s byte %0d: expected %h, actual %h", test_name,
                                 rd_idx, exp_bytes[rd_idx], act_bytes[rd_idx]);
                        mismatch_errs++;
                    end
                    assert (exp_addr[rd_idx] < 0 || act_addr[rd_idx] == exp_addr[rd_idx])
                    else
                    begin
                        $display("Mismatch %s reg_addr: expected %0d, actual %0d", test_name,
                                 exp_addr[rd_idx], act_addr[rd_idx]);
                        mismatch_errs++;
                    end
                end
                rd_idx++;
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(82));
        check_errs = 0;
        exp_cnt    = 0;
        rst_n_in   = 1'b0;
        start      = 1'b0;
        req        = '0;
        for (int a = 0; a < 256; a++)
            store[a] = 16'(a * 257);
        repeat (5) @(posedge clk_in);
        rst_n_in <= 1'b1;
        @(negedge clk_in);
        assert (rs485_tx_en === 1'b0 && rs485_tx === 1'b1)
        else
        begin
            $display("enable or serial line wrong after reset");
            check_errs++;
        end
        for (int n = 1; n <= MAX_COUNT; n++)
            run_test($sformatf("fc03_count%0d", n), FC_READ_HOLDING, n, 1'b0);
        run_test("fc04_count1", FC_READ_INPUT, 1, 1'b0);
        run_test("fc03_second_start", FC_READ_HOLDING, 3, 1'b1);
        @(negedge clk_in);
        $display("errors: %0d mismatch, %0d framing, %0d check, %0d assertion", mismatch_errs,
                 frame_errs, check_errs, dut_i.checker_i.fail_cnt);
        if (mismatch_errs + frame_errs + check_errs + dut_i.checker_i.fail_cnt == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- logic/baud_timer.sv
`timescale 1ns/1ns

module baud_timer
#(
    parameter logic [15:0] BAUD_DIV = modbus_pkg::BAUD_DIV_DEFAULT
)
(
    input  logic clk_in,
    input  logic rst_n_in,
    input  logic run,
    input  logic guard_start,
    output logic bit_tick,
    output logic guard_done
);
    import modbus_pkg::*;

    logic [15:0] div_cnt;
    logic [3:0]  guard_cnt;
    logic        guard_active;

    assign bit_tick   = run && (div_cnt == BAUD_DIV - 16'd1);
    assign guard_done = guard_active && bit_tick && (guard_cnt == GUARD_BITS - 4'd1);

    // divider restarts from zero whenever run drops
    always_ff @(posedge clk_in or negedge rst_n_in)
    begin
        if (!rst_n_in)
            div_cnt <= 16'd0;
        else if (!run || bit_tick)
            div_cnt <= 16'd0;
        else
            div_cnt <= div_cnt + 16'd1;
    end

    always_ff @(posedge clk_in or negedge rst_n_in)
    begin
        if (!rst_n_in)
        begin
            guard_active <= 1'b0;
            guard_cnt    <= 4'd0;
        end
        else if (guard_start)
        begin
            guard_active <= 1'b1;
            guard_cnt    <= 4'd0;
        end
        else if (guard_done)
            guard_active <= 1'b0;
        else if (guard_active && bit_tick)
            guard_cnt <= guard_cnt + 4'd1;
    end

endmodule

//--- logic/crc16_modbus.sv
`timescale 1ns/1ns

module crc16_modbus
(
    input  logic                  clk_in,
    input  logic                  rst_n_in,
    input  logic                  clear,
    input  modbus_pkg::byte_req_t data_in,
    output logic [15:0]           crc_value,
    output logic                  busy
);
    import modbus_pkg::*;

    logic [2:0] step_cnt;

    // one shift step per cycle, eight per byte
    always_ff @(posedge clk_in or negedge rst_n_in)
    begin
        if (!rst_n_in)
        begin
            crc_value <= CRC_INIT;
            busy      <= 1'b0;
            step_cnt  <= 3'd0;
        end
        else if (clear)
        begin
            crc_value <= CRC_INIT;
            busy      <= 1'b0;
            step_cnt  <= 3'd0;
        end
        else if (busy)
        begin
            if (crc_value[0])
                crc_value <= (crc_value >> 1) ^ CRC_POLY;
            else
                crc_value <= crc_value >> 1;
            step_cnt <= step_cnt + 3'd1;
            if (step_cnt == 3'd7)
                busy <= 1'b0;
        end
        else if (data_in.valid)
        begin
            crc_value <= crc_value ^ {8'h00, data_in.data}; // byte into low half
            busy      <= 1'b1;
            step_cnt  <= 3'd0;
        end
    end

endmodule

//--- logic/modbus_pkg.sv
package modbus_pkg;

    // slave identity and serial line
    localparam logic [7:0]  SLAVE_ADDR  = 8'h01;
    localparam int          CLK_FREQ_HZ = 50_000_000;
    localparam int          BAUD_RATE   = 9600;

    localparam logic [15:0] BAUD_DIV_DEFAULT = 16'(CLK_FREQ_HZ / BAUD_RATE); // clocks per bit

    localparam logic [3:0]  GUARD_BITS = 4'd10;   // driver enable lead and tail
    localparam logic [7:0]  MAX_REGS   = 8'd125;  // largest read per request

    // crc-16 modbus in reflected form
    localparam logic [15:0] CRC_INIT = 16'hFFFF;
    localparam logic [15:0] CRC_POLY = 16'hA001;

    typedef enum logic [7:0]
    {
        FC_READ_HOLDING = 8'h03,
        FC_READ_INPUT   = 8'h04
    } func_code_e;

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_GUARD_PRE,
        S_LOAD,
        S_SEND,
        S_GUARD_POST
    } seq_state_e;

    // read request as handed in with the start pulse
    typedef struct packed
    {
        func_code_e func;
        logic [7:0] reg_count;
    } resp_req_t;

    // one frame byte on its way to the uart and the crc unit
    typedef struct packed
    {
        logic       valid;
        logic [7:0] data;
    } byte_req_t;

endpackage

//--- logic/modbus_resp_tx.sv
`timescale 1ns/1ns

module modbus_resp_tx
#(
    parameter logic [15:0] BAUD_DIV = modbus_pkg::BAUD_DIV_DEFAULT
)
(
    input  logic                  clk_in,
    input  logic                  rst_n_in,
    input  logic                  start,
    input  modbus_pkg::resp_req_t req,
    output logic [7:0]            reg_addr,
    input  logic [15:0]           reg_data,
    output logic                  rs485_tx,
    output logic                  rs485_tx_en,
    output logic                  response_done
);
    import modbus_pkg::*;

    byte_req_t   tx_byte;      // shared by uart and crc
    logic        tx_busy;
    logic        tx_done;
    logic        crc_clear;
    logic [15:0] crc_value;
    logic        crc_busy;
    logic        timer_run;
    logic        guard_start;
    logic        guard_done;
    logic        bit_tick;

    resp_sequencer seq_i
    (
        .clk_in        (clk_in),
        .rst_n_in      (rst_n_in),
        .start         (start),
        .req           (req),
        .reg_addr      (reg_addr),
        .reg_data      (reg_data),
        .tx_byte       (tx_byte),
        .tx_busy       (tx_busy),
        .tx_done       (tx_done),
        .crc_clear     (crc_clear),
        .crc_value     (crc_value),
        .crc_busy      (crc_busy),
        .timer_run     (timer_run),
        .guard_start   (guard_start),
        .guard_done    (guard_done),
        .rs485_tx_en   (rs485_tx_en),
        .response_done (response_done)
    );

    baud_timer #(.BAUD_DIV(BAUD_DIV)) timer_i
    (
        .clk_in      (clk_in),
        .rst_n_in    (rst_n_in),
        .run         (timer_run),
        .guard_start (guard_start),
        .bit_tick    (bit_tick),
        .guard_done  (guard_done)
    );

    crc16_modbus crc_i
    (
        .clk_in    (clk_in),
        .rst_n_in  (rst_n_in),
        .clear     (crc_clear),
        .data_in   (tx_byte),
        .crc_value (crc_value),
        .busy      (crc_busy)
    );

    uart_byte_tx uart_i
    (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .tx_byte  (tx_byte),
        .bit_tick (bit_tick),
        .busy     (tx_busy),
        .done     (tx_done),
        .tx       (rs485_tx)
    );

endmodule

//--- logic/resp_sequencer.sv
`timescale 1ns/1ns

module resp_sequencer
(
    input  logic                  clk_in,
    input  logic                  rst_n_in,
    input  logic                  start,
    input  modbus_pkg::resp_req_t req,
    output logic [7:0]            reg_addr,
    input  logic [15:0]           reg_data,
    output modbus_pkg::byte_req_t tx_byte,
    input  logic                  tx_busy,
    input  logic                  tx_done,
    output logic                  crc_clear,
    input  logic [15:0]           crc_value,
    input  logic                  crc_busy,
    output logic                  timer_run,
    output logic                  guard_start,
    input  logic                  guard_done,
    output logic                  rs485_tx_en,
    output logic                  response_done
);
    import modbus_pkg::*;

    seq_state_e state;
    resp_req_t  req_q;
    logic [7:0] byte_idx;
    logic [7:0] crc_idx;     // index of crc low byte
    logic [7:0] next_data;
    logic [7:0] crc_hi;

    assign timer_run = (state != S_IDLE);
    assign crc_idx   = 8'd3 + {req_q.reg_count[6:0], 1'b0};

    // frame byte at byte_idx; odd indices in the data field carry the high byte
    always_comb
    begin
        if (byte_idx == 8'd0)
            next_data = SLAVE_ADDR;
        else if (byte_idx == 8'd1)
            next_data = req_q.func;
        else if (byte_idx == 8'd2)
            next_data = {req_q.reg_count[6:0], 1'b0};
        else if (byte_idx < crc_idx)
            next_data = byte_idx[0] ? reg_data[15:8] : reg_data[7:0];
        else if (byte_idx == crc_idx)
            next_data = crc_value[7:0];
        else
            next_data = crc_hi;
    end

    // crc bytes also reach the crc unit, so hold the high half here
    always_ff @(posedge clk_in)
    begin
        if (state == S_LOAD && byte_idx == crc_idx)
            crc_hi <= crc_value[15:8];
    end

    always_ff @(posedge clk_in or negedge rst_n_in)
    begin
        if (!rst_n_in)
        begin
            state         <= S_IDLE;
            req_q         <= '{func: FC_READ_HOLDING, reg_count: 8'd0};
            byte_idx      <= 8'd0;
            reg_addr      <= 8'd0;
            tx_byte       <= '0;
            crc_clear     <= 1'b0;
            guard_start   <= 1'b0;
            rs485_tx_en   <= 1'b0;
            response_done <= 1'b0;
        end
        else
        begin
            tx_byte.valid <= 1'b0;
            crc_clear     <= 1'b0;
            guard_start   <= 1'b0;
            response_done <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (start)
                    begin
                        req_q.func      <= req.func;
                        req_q.reg_count <= (req.reg_count > MAX_REGS) ? MAX_REGS : req.reg_count;
                        byte_idx        <= 8'd0;
                        reg_addr        <= 8'd0;
                        crc_clear       <= 1'b1;
                        guard_start     <= 1'b1;
                        rs485_tx_en     <= 1'b1;
                        state           <= S_GUARD_PRE;
                    end
                end
                S_GUARD_PRE:
                begin
                    if (guard_done)
                        state <= S_LOAD;
                end
                S_LOAD:
                begin
                    if (!tx_busy && !crc_busy)
                    begin
                        tx_byte <= '{valid: 1'b1, data: next_data};
                        state   <= S_SEND;
                    end
                end
                S_SEND:
                begin
                    if (tx_done)
                    begin
                        if (byte_idx == crc_idx + 8'd1)
                        begin
                            guard_start <= 1'b1;
                            state       <= S_GUARD_POST;
                        end
                        else
                        begin
                            // step word address after each low data byte
                            if (byte_idx >= 8'd3 && byte_idx < crc_idx && !byte_idx[0])
                                reg_addr <= reg_addr + 8'd1;
                            byte_idx <= byte_idx + 8'd1;
                            state    <= S_LOAD;
                        end
                    end
                end
                S_GUARD_POST:
                begin
                    if (guard_done)
                    begin
                        rs485_tx_en   <= 1'b0;
                        response_done <= 1'b1;
                        state         <= S_IDLE;
                    end
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- logic/uart_byte_tx.sv
`timescale 1ns/1ns

module uart_byte_tx
(
    input  logic                  clk_in,
    input  logic                  rst_n_in,
    input  modbus_pkg::byte_req_t tx_byte,
    input  logic                  bit_tick,
    output logic                  busy,
    output logic                  done,
    output logic                  tx
);

    logic [9:0] shreg;
    logic [3:0] bit_cnt;

    // stop, data lsb first, start
    always_ff @(posedge clk_in)
    begin
        if (!busy && tx_byte.valid)
            shreg <= {1'b1, tx_byte.data, 1'b0};
        else if (busy && bit_tick)
            shreg <= {1'b1, shreg[9:1]};
    end

    always_ff @(posedge clk_in or negedge rst_n_in)
    begin
        if (!rst_n_in)
        begin
            busy    <= 1'b0;
            done    <= 1'b0;
            tx      <= 1'b1;
            bit_cnt <= 4'd0;
        end
        else
        begin
            done <= 1'b0;
            if (!busy)
            begin
                if (tx_byte.valid)
                begin
                    busy    <= 1'b1;
                    bit_cnt <= 4'd0;
                end
            end
            else if (bit_tick)
            begin
                if (bit_cnt == 4'd10)
                begin
                    // this tick closes the stop bit
                    busy <= 1'b0;
                    done <= 1'b1;
                    tx   <= 1'b1;
                end
                else
                begin
                    tx      <= shreg[0];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

endmodule

//--- modbus_resp_tx.f
logic/modbus_pkg.sv
logic/baud_timer.sv
logic/crc16_modbus.sv
logic/uart_byte_tx.sv
logic/resp_sequencer.sv
logic/modbus_resp_tx.sv
bench/modbus_resp_tx_checker.sv
bench/modbus_resp_tx_tb.sv
